//--- src/shift_buffer_cfg_pkg.sv
`default_nettype none

package shift_buffer_cfg_pkg;

    localparam int DATA_WIDTH   = 8;    // bits per word
    localparam int CONV_UNITS   = 4;    // words per output beat
    localparam int KERNEL_H_MAX = 3;

    // padded input row, enough words for the tallest kernel
    localparam int IN_WORDS = CONV_UNITS + KERNEL_H_MAX - 1;

    // holds kernel_h - 1, at least one bit even for KERNEL_H_MAX of 1
    localparam int KERNEL_H_WIDTH = (KERNEL_H_MAX > 1) ? $clog2(KERNEL_H_MAX) : 1;

    localparam int CIN_WIDTH = 6;       // input channel count

    typedef logic [DATA_WIDTH-1:0] word_t;

    typedef word_t in_row_t [IN_WORDS];      // one input beat
    typedef word_t out_row_t [CONV_UNITS];   // one shifted output beat

    typedef logic [KERNEL_H_WIDTH-1:0] kernel_h_1_t;   // kernel_h - 1
    typedef logic [CIN_WIDTH-1:0]      cin_1_t;        // cin - 1

endpackage

`default_nettype wire

//--- src/shift_buffer_flags_pkg.sv
`default_nettype none

package shift_buffer_flags_pkg;

    localparam int TUSER_WIDTH = 3;

    // bit positions inside tuser
    localparam int IDX_IS_1X1  = 0;   // kernel_h of one
    localparam int IDX_IS_MAX  = 1;   // max pooling follows
    localparam int IDX_IS_RELU = 2;   // relu follows

    typedef logic [TUSER_WIDTH-1:0] tuser_t;

endpackage

`default_nettype wire

//--- src/skid_buffer.sv
`timescale 1ns/100ps
`default_nettype none

// two entry register slice, ready comes straight from a flop
module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     rst_n,
    input  payload_t s_data,
    input  logic     s_valid,
    output logic     s_ready,
    output payload_t m_data,
    output logic     m_valid,
    input  logic     m_ready
);

    payload_t main_q;      // drives the output
    payload_t skid_q;      // parks a beat when main is stalled
    logic     main_valid;
    logic     skid_valid;

    logic main_free;       // main register can take a new beat
    logic in_xfer;
    logic load_main_in;    // main takes s_data
    logic load_skid;       // skid takes s_data

    assign s_ready = ~skid_valid;   // low only when both entries hold data
    assign m_data  = main_q;
    assign m_valid = main_valid;

    assign main_free    = ~main_valid | m_ready;
    assign in_xfer      = s_valid & s_ready;
    assign load_main_in = main_free & ~skid_valid & in_xfer;
    assign load_skid    = ~main_free & in_xfer;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            if (skid_valid) begin
                main_valid <= 1'b1;         // drain the parked beat first
                skid_valid <= 1'b0;
            end else begin
                main_valid <= in_xfer;
            end
        end else if (load_skid) begin
            skid_valid <= 1'b1;             // main stalled, park incoming beat
        end
    end

    // payload path
    always_ff @(posedge aclk) begin
        if (main_free && skid_valid)
            main_q <= skid_q;
        else if (load_main_in)
            main_q <= s_data;
        if (load_skid)
            skid_q <= s_data;
    end

endmodule

`default_nettype wire

//--- src/shift_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

module shift_config_regs
    import shift_buffer_cfg_pkg::*;
    import shift_buffer_flags_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,
    input  logic        start,          // one cycle, only while idle
    input  kernel_h_1_t kernel_h_1_in,
    input  cin_1_t      cin_1_in,
    input  logic        is_max_in,
    input  logic        is_relu_in,
    output kernel_h_1_t kernel_h_1,
    output cin_1_t      cin_1,
    output tuser_t      m_user
);

    logic is_1x1_q;
    logic is_max_q;
    logic is_relu_q;

    // sampled on start, held until the next one
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            kernel_h_1 <= '0;
            cin_1      <= '0;
            is_1x1_q   <= 1'b0;
            is_max_q   <= 1'b0;
            is_relu_q  <= 1'b0;
        end else if (start) begin
            kernel_h_1 <= kernel_h_1_in;
            cin_1      <= cin_1_in;
            is_1x1_q   <= (kernel_h_1_in == '0);   // single shift per row
            is_max_q   <= is_max_in;
            is_relu_q  <= is_relu_in;
        end
    end

    // flags packed at their tuser positions
    always_comb begin
        m_user              = '0;
        m_user[IDX_IS_1X1]  = is_1x1_q;
        m_user[IDX_IS_MAX]  = is_max_q;
        m_user[IDX_IS_RELU] = is_relu_q;
    end

endmodule

`default_nettype wire

//--- src/shift_window.sv
`timescale 1ns/100ps
`default_nettype none

module shift_window
    import shift_buffer_cfg_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,
    input  kernel_h_1_t kernel_h_1,     // held config
    input  in_row_t     row,
    input  logic        row_valid,
    output logic        row_ready,
    output out_row_t    m_data,
    output logic        m_valid,
    input  logic        m_ready,
    output logic        shift_last      // beat shown is the final shift
);

    word_t       win [IN_WORDS];    // window registers, word 0 is lowest
    kernel_h_1_t shift_idx;         // shift of the beat shown
    logic        win_valid;

    logic out_xfer;
    logic load;
    logic advance;

    assign shift_last = win_valid & (shift_idx == kernel_h_1);
    assign m_valid    = win_valid;
    assign out_xfer   = win_valid & m_ready;

    // next row may enter when empty or the final shift leaves now
    assign row_ready = ~win_valid | (m_ready & shift_last);
    assign load      = row_valid & row_ready;
    assign advance   = out_xfer & ~shift_last;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
            shift_idx <= '0;
        end else if (load) begin
            win_valid <= 1'b1;
            shift_idx <= '0;                // new row starts at shift 0
        end else if (out_xfer && shift_last) begin
            win_valid <= 1'b0;              // row done, nothing waiting
        end else if (advance) begin
            shift_idx <= kernel_h_1_t'(shift_idx + 1'b1);
        end
    end

    // data path, no reset
    always_ff @(posedge aclk) begin
        if (load) begin
            win <= row;
        end else if (advance) begin
            for (int i = 0; i < IN_WORDS - 1; i++)
                win[i] <= win[i+1];         // slide down one word
            // top word keeps its value
        end
    end

    // lowest CONV_UNITS words form the output beat
    always_comb begin
        for (int i = 0; i < CONV_UNITS; i++)
            m_data[i] = win[i];
    end

endmodule

`default_nettype wire

//--- src/cin_tlast_gen.sv
`timescale 1ns/100ps
`default_nettype none

module cin_tlast_gen
    import shift_buffer_cfg_pkg::*;
(
    input  logic   aclk,
    input  logic   rst_n,
    input  logic   start,
    input  cin_1_t cin_1,          // held cin - 1
    input  logic   m_valid,
    input  logic   m_ready,
    input  logic   shift_last,
    output logic   m_last
);

    cin_1_t cin_count;    // input channel of the row being shown
    logic   row_done;     // final shift of a row transferred

    assign row_done = m_valid & m_ready & shift_last;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cin_count <= '0;
        end else if (start) begin
            cin_count <= '0;                        // new group from start
        end else if (row_done) begin
            if (cin_count == cin_1)
                cin_count <= '0;                    // wrap after last channel
            else
                cin_count <= cin_1_t'(cin_count + 1'b1);
        end
    end

    // lines up with m_data, no extra register
    assign m_last = shift_last & (cin_count == cin_1);

endmodule

`default_nettype wire

//--- src/axis_shift_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module axis_shift_buffer
    import shift_buffer_cfg_pkg::*;
    import shift_buffer_flags_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,
    input  logic        start,

    input  kernel_h_1_t kernel_h_1,     // kernel_h - 1
    input  cin_1_t      cin_1,          // cin - 1
    input  logic        is_max,
    input  logic        is_relu,

    input  in_row_t     s_data,         // padded row
    input  logic        s_valid,
    output logic        s_ready,

    output out_row_t    m_data,         // one shifted view
    output logic        m_valid,
    input  logic        m_ready,
    output logic        m_last,
    output tuser_t      m_user,

    output kernel_h_1_t kernel_h_1_out  // held value for next stage
);

    in_row_t row;           // slice to window
    logic    row_valid;
    logic    row_ready;
    cin_1_t  cin_1_held;
    logic    shift_last;

    // input register slice
    skid_buffer #(
        .payload_t (in_row_t)
    ) u_skid (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .s_data  (s_data),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (row),
        .m_valid (row_valid),
        .m_ready (row_ready)
    );

    shift_config_regs u_cfg (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .start         (start),
        .kernel_h_1_in (kernel_h_1),
        .cin_1_in      (cin_1),
        .is_max_in     (is_max),
        .is_relu_in    (is_relu),
        .kernel_h_1    (kernel_h_1_out),
        .cin_1         (cin_1_held),
        .m_user        (m_user)
    );

    // kernel_h shifted beats per row
    shift_window u_window (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .kernel_h_1 (kernel_h_1_out),
        .row        (row),
        .row_valid  (row_valid),
        .row_ready  (row_ready),
        .m_data     (m_data),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .shift_last (shift_last)
    );

    cin_tlast_gen u_tlast (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .start      (start),
        .cin_1      (cin_1_held),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .shift_last (shift_last),
        .m_last     (m_last)
    );

endmodule

`default_nettype wire

//--- testbench/tb_axis_shift_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axis_shift_buffer
    import shift_buffer_cfg_pkg::*;
    import shift_buffer_flags_pkg::*;
();

    localparam int OUT_BITS   = CONV_UNITS * DATA_WIDTH;
    localparam int WAIT_LIMIT = 2000;   // cycles per wait
    localparam int MAX_GAP    = 8;      // longest s_valid gap
    localparam int NUM_CFG    = 6;

    // kernel_h_1, cin_1, is_max, is_relu, rows, gap percent
    localparam int CFG_TABLE [NUM_CFG][6] = '{
        '{0, 1, 0, 1,  6,  0},    // 1x1 at full rate
        '{1, 2, 1, 0,  9, 30},
        '{2, 3, 1, 1, 10, 40},
        '{2, 0, 0, 0,  5,  0},    // cin of one gives tlast every row
        '{1, 4, 0, 1, 12,  0},
        '{0, 2, 1, 1,  7, 50}
    };

    logic        aclk = 1'b0;
    logic        rst_n;
    logic        start;
    kernel_h_1_t kernel_h_1;
    cin_1_t      cin_1;
    logic        is_max;
    logic        is_relu;
    in_row_t     s_data;
    logic        s_valid;
    logic        s_ready;
    out_row_t    m_data;
    logic        m_valid;
    logic        m_ready;
    logic        m_last;
    tuser_t      m_user;
    kernel_h_1_t kernel_h_1_out;

    logic [OUT_BITS-1:0] exp_data_q [$];    // model output beats
    logic                exp_last_q [$];

    kernel_h_1_t         cap_kh1;           // config as captured at start
    cin_1_t              cap_cin1;
    tuser_t              cap_user;
    int                  row_in_group;
    int                  ready_gap;
    logic [31:0]         data_state = 32'd78;
    logic [31:0]         rdy_state  = ~32'd78;
    int                  mismatches = 0;
    int                  failures   = 0;
    int                  cycle_cnt  = 0;
    int                  xfer_cnt;
    int                  first_cycle;
    int                  last_cycle;
    logic                hold_pending = 1'b0;
    logic [OUT_BITS-1:0] data_hold;
    logic                last_hold;
    tuser_t              user_hold;
    logic [OUT_BITS-1:0] got_data;

    axis_shift_buffer u_dut (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .start          (start),
        .kernel_h_1     (kernel_h_1),
        .cin_1          (cin_1),
        .is_max         (is_max),
        .is_relu        (is_relu),
        .s_data         (s_data),
        .s_valid        (s_valid),
        .s_ready        (s_ready),
        .m_data         (m_data),
        .m_valid        (m_valid),
        .m_ready        (m_ready),
        .m_last         (m_last),
        .m_user         (m_user),
        .kernel_h_1_out (kernel_h_1_out)
    );

    always #5 aclk = ~aclk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [OUT_BITS-1:0] pack_out(input out_row_t r);
        logic [OUT_BITS-1:0] p;
        for (int i = 0; i < CONV_UNITS; i++)
            p[i*DATA_WIDTH +: DATA_WIDTH] = r[i];   // word 0 at the bottom
        return p;
    endfunction

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        failures++;
        $display("Timeout while waiting for %s at %0t", what, $time);
        finish_run();
    endtask

    // kernel_h beats per row
    // shift s shows words s .. s+CONV_UNITS-1
    task automatic push_model(input word_t w [IN_WORDS]);
        logic [OUT_BITS-1:0] beat;
        for (int s = 0; s <= int'(cap_kh1); s++) begin
            for (int i = 0; i < CONV_UNITS; i++)
                beat[i*DATA_WIDTH +: DATA_WIDTH] = w[s+i];
            exp_data_q.push_back(beat);
            exp_last_q.push_back(s == int'(cap_kh1) && row_in_group == int'(cap_cin1));
        end
        row_in_group = (row_in_group == int'(cap_cin1)) ? 0 : row_in_group + 1;
    endtask

    // starts on a falling edge and returns on the one after the transfer
    task automatic send_row(input int gap);
        word_t w [IN_WORDS];
        int    idle_cnt;
        int    wait_cnt;
        logic  accepted;
        idle_cnt = 0;
        data_state = lcg_step(data_state);
        while (idle_cnt < MAX_GAP && int'(data_state[30:16]) % 100 < gap) begin
            s_valid = 1'b0;
            @(negedge aclk);
            idle_cnt++;
            data_state = lcg_step(data_state);
        end
        for (int i = 0; i < IN_WORDS; i++) begin
            data_state = lcg_step(data_state);
            w[i] = data_state[23:16];
            s_data[i] = w[i];
        end
        s_valid = 1'b1;
        wait_cnt = 0;
        accepted = 1'b0;
        while (!accepted && wait_cnt < WAIT_LIMIT) begin
            @(posedge aclk);
            accepted = s_ready;     // pre-edge value decides the handshake
            wait_cnt++;
        end
        if (!accepted)
            abort_on_timeout("s_ready on an input row");
        push_model(w);
        @(negedge aclk);
    endtask

    task automatic wait_idle(input string what);
        int cnt;
        cnt = 0;
        while ((exp_data_q.size() != 0 || m_valid) && cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            cnt++;
        end
        if (exp_data_q.size() != 0 || m_valid)
            abort_on_timeout(what);
    endtask

    // random back-pressure from a second LCG stream
    always @(negedge aclk) begin
        rdy_state = lcg_step(rdy_state);
        m_ready = (ready_gap == 0) || (int'(rdy_state[30:16]) % 100 >= ready_gap);
    end

    // monitor sees the pre-edge values
    always @(posedge aclk) begin
        if (rst_n) begin
            cycle_cnt++;
            got_data = pack_out(m_data);
            if (hold_pending) begin
                assert (m_valid && got_data == data_hold && m_last == last_hold &&
                        m_user == user_hold)
                else begin
                    mismatches++;
                    $display("Mismatch at %0t: output changed while stalled", $time);
                end
            end
            hold_pending = m_valid && !m_ready;
            data_hold    = got_data;
            last_hold    = m_last;
            user_hold    = m_user;
            if (m_valid && m_ready) begin
                assert (exp_data_q.size() != 0)
                else begin
                    failures++;
                    $display("Output beat at %0t with no beat left in the model", $time);
                end
                if (exp_data_q.size() != 0) begin
                    assert (got_data == exp_data_q[0])
                    else begin
                        mismatches++;
                        $display("Mismatch at %0t: m_data %h, expected %h", $time,
                                 got_data, exp_data_q[0]);
                    end
                    assert (m_last == exp_last_q[0])
                    else begin
                        mismatches++;
                        $display("Mismatch at %0t: m_last %b, expected %b", $time,
                                 m_last, exp_last_q[0]);
                    end
                    void'(exp_data_q.pop_front());
                    void'(exp_last_q.pop_front());
                end
                assert (m_user == cap_user && kernel_h_1_out == cap_kh1)
                else begin
                    mismatches++;
                    $display("Mismatch at %0t: m_user %b kernel_h_1_out %0d, expected %b %0d",
                             $time, m_user, kernel_h_1_out, cap_user, cap_kh1);
                end
                if (xfer_cnt == 0)
                    first_cycle = cycle_cnt;
                last_cycle = cycle_cnt;
                xfer_cnt++;
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        kernel_h_1 = '0;
        cin_1      = '0;
        is_max     = 1'b0;
        is_relu    = 1'b0;
        s_valid    = 1'b0;
        m_ready    = 1'b0;
        ready_gap  = 0;
        cap_kh1    = '0;
        cap_cin1   = '0;
        cap_user   = '0;
        xfer_cnt   = 0;
        for (int i = 0; i < IN_WORDS; i++)
            s_data[i] = '0;
        repeat (3) @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);
        assert (!m_valid && !m_last && m_user == '0 && s_ready && kernel_h_1_out == '0)
        else begin
            mismatches++;
            $display("Mismatch at %0t: outputs not idle after reset", $time);
        end

        for (int c = 0; c < NUM_CFG; c++) begin
            wait_idle("the buffer to go idle before start");
            ready_gap  = CFG_TABLE[c][5];
            kernel_h_1 = kernel_h_1_t'(CFG_TABLE[c][0]);
            cin_1      = cin_1_t'(CFG_TABLE[c][1]);
            is_max     = CFG_TABLE[c][2][0];
            is_relu    = CFG_TABLE[c][3][0];
            cap_kh1    = kernel_h_1;
            cap_cin1   = cin_1;
            cap_user   = '0;
            cap_user[IDX_IS_1X1]  = (CFG_TABLE[c][0] == 0);    // kernel_h of one
            cap_user[IDX_IS_MAX]  = is_max;
            cap_user[IDX_IS_RELU] = is_relu;
            row_in_group = 0;
            xfer_cnt     = 0;
            start = 1'b1;
            @(negedge aclk);
            start = 1'b0;
            // scrambled inputs must not reach the held config
            kernel_h_1 = ~kernel_h_1;
            cin_1      = ~cin_1;
            is_max     = ~is_max;
            is_relu    = ~is_relu;
            assert (kernel_h_1_out == cap_kh1 && m_user == cap_user)
            else begin
                mismatches++;
                $display("Mismatch at %0t: config not captured on start", $time);
            end
            for (int r = 0; r < CFG_TABLE[c][4]; r++)
                send_row(CFG_TABLE[c][5]);
            s_valid = 1'b0;
            wait_idle("the last output beat of a config");
            assert (xfer_cnt == CFG_TABLE[c][4] * (CFG_TABLE[c][0] + 1))
            else begin
                mismatches++;
                $display("Mismatch at %0t: %0d beats for config %0d", $time, xfer_cnt, c);
            end
            // full rate gives one beat every cycle from the first one on
            if (CFG_TABLE[c][5] == 0) begin
                assert (last_cycle - first_cycle + 1 == xfer_cnt)
                else begin
                    mismatches++;
                    $display("Mismatch at %0t: gap in full rate output, config %0d",
                             $time, c);
                end
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- verilog.f
src/shift_buffer_cfg_pkg.sv
src/shift_buffer_flags_pkg.sv
src/skid_buffer.sv
src/shift_config_regs.sv
src/shift_window.sv
src/cin_tlast_gen.sv
src/axis_shift_buffer.sv
testbench/tb_axis_shift_buffer.sv
